//--- list.f
logic/flag_read_pkg.sv
logic/flag_buf_if.sv
logic/burst_filler.sv
logic/pingpong_ram.sv
logic/marker_scanner.sv
logic/timed_flag_read.sv
dv/timed_flag_read_asserts.sv
dv/tb_timed_flag_read.sv

//--- Makefile
TOP = tb_timed_flag_read

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- dv/tb_timed_flag_read.sv
`timescale 1ns/1ps
`default_nettype none

module tb_timed_flag_read;

   localparam int n_frames     = 12;
   localparam int max_len      = 24;
   localparam int scan_cycles  = 40;
   localparam int frame_cycles = max_len * 4 + scan_cycles;
   localparam int timeout_ns   = (n_frames + 1) * frame_cycles * 4;

   logic        clk;
   logic        rst;
   logic        run;
   logic        running;
   logic        disabled;
   logic        done;
   logic [31:0] out0;
   logic [31:0] in0;
   logic [31:0] maximum;
   logic [31:0] delay0;
   logic [31:0] ext_addr;
   logic [7:0]  length;
   logic        databus_valid;
   logic        databus_ready;
   logic [31:0] databus_addr;
   logic [31:0] databus_rdata;
   logic [7:0]  databus_len;
   logic        databus_last;

   // reference model
   logic [15:0] cur_list [$];  // words loaded this frame
   logic [15:0] prev_list [$]; // words being scanned
   bit          prev_known;
   int          scan_ptr;
   int unsigned delay_cnt;
   bit          still_valid_m;
   bit          bus_active_m;
   int          beat_m;
   logic [31:0] frame_addr;
   logic [7:0]  frame_len;
   logic [31:0] frame_delay;

   integer      seed;
   int          n_checks;
   int          n_errors;
   bit          done_seen;

   timed_flag_read u_dut (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .running       (running),
      .disabled      (disabled),
      .done          (done),
      .out0          (out0),
      .in0           (in0),
      .maximum       (maximum),
      .delay0        (delay0),
      .ext_addr      (ext_addr),
      .length        (length),
      .databus_valid (databus_valid),
      .databus_ready (databus_ready),
      .databus_addr  (databus_addr),
      .databus_rdata (databus_rdata),
      .databus_len   (databus_len),
      .databus_last  (databus_last)
   );

   always #2 clk = ~clk;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // drive one falling edge, check the settled outputs, then advance the model
   task automatic drive_cycle(input bit do_run, input bit run_on, input bit dis,
                              input bit want_match, input bit over_max);
      logic [15:0] lo;
      logic [14:0] hi;
      bit          hit;
      bit          exp_done;
      @(negedge clk);
      run      = do_run;
      running  = run_on;
      disabled = dis;
      if (do_run) begin
         ext_addr = frame_addr;
         length   = frame_len;
         delay0   = frame_delay;
      end
      if (databus_valid && ($random(seed) & 3) != 0) begin
         databus_ready = 1'b1;
         databus_rdata = frame_addr + 32'(beat_m * 7);
         databus_last  = (beat_m == int'(frame_len) - 1);
      end else begin
         databus_ready = 1'b0;
         databus_rdata = $random(seed);
         databus_last  = 1'b0;
      end
      lo = 16'($random(seed));
      hi = 15'($random(seed));
      if (prev_known) begin
         if (want_match && scan_ptr < prev_list.size() - 1) begin
            lo = prev_list[scan_ptr];
         end else if (lo == prev_list[scan_ptr]) begin
            lo = ~lo; // keep misses real
         end
      end
      in0 = {over_max, hi, lo};
      #1;
      hit      = prev_known && (in0[15:0] == prev_list[scan_ptr]);
      exp_done = (!running || disabled || !still_valid_m) && !bus_active_m;
      check("databus_valid", 32'(databus_valid), 32'(bus_active_m));
      if (bus_active_m) begin
         check("databus_addr", databus_addr, frame_addr);
         check("databus_len", 32'(databus_len), 32'(frame_len));
      end
      check("done", 32'(done), 32'(exp_done));
      if (delay_cnt != 0 || disabled) begin
         check("out0", out0, 32'd0);
      end else if (prev_known) begin
         check("out0", out0, hit ? 32'hffff_ffff : 32'd0);
      end
      if (do_run) begin
         prev_known = (cur_list.size() > 0);
         prev_list  = cur_list;
         cur_list.delete();
         scan_ptr      = 0;
         delay_cnt     = frame_delay + 32'd1;
         still_valid_m = 1'b1;
         bus_active_m  = 1'b1;
         beat_m        = 0;
      end else begin
         if (bus_active_m && databus_ready) begin
            cur_list.push_back(databus_rdata[15:0]);
            beat_m++;
            if (databus_last) begin
               bus_active_m = 1'b0;
            end
         end
         if (running && delay_cnt == 0 && hit) begin
            scan_ptr++;
         end
         if (delay_cnt != 0) begin
            delay_cnt--;
         end
         if (running && in0 >= maximum) begin
            still_valid_m = 1'b0;
         end
      end
      done_seen = done;
   endtask

   initial begin
      #(timeout_ns);
      $display("watchdog: run went past %0d ns without finishing", timeout_ns);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      int f;
      int c;
      int mode;
      int waited;
      int errs_before;
      int max_at;
      bit dis;
      seed = 32'hdaa8_04db;
      clk = 1'b0;
      rst = 1'b1;
      run = 1'b0;
      running = 1'b0;
      disabled = 1'b0;
      in0 = '0;
      maximum = 32'h8000_0000; // reached only when in0[31] is set
      delay0 = '0;
      ext_addr = '0;
      length = '0;
      databus_ready = 1'b0;
      databus_rdata = '0;
      databus_last = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      #1;
      check("out0", out0, 32'd0);
      repeat (2) drive_cycle(0, 0, 0, 0, 0);

      for (f = 0; f < n_frames; f++) begin
         mode        = f % 3; // plain, disable, maximum
         errs_before = n_errors;
         frame_addr  = $random(seed);
         frame_len   = 8'(1 + ($unsigned($random(seed)) % max_len));
         frame_delay = 32'(2 + ($unsigned($random(seed)) % 6));
         max_at      = int'(4 + ($unsigned($random(seed)) % (scan_cycles - 4)));
         drive_cycle(1, 1, 0, 0, 0);
         for (c = 0; c < scan_cycles; c++) begin
            dis = (mode == 1) && (($random(seed) & 3) == 0);
            drive_cycle(0, 1, dis, ($random(seed) & 1) == 1, (mode == 2) && (c == max_at));
         end
         waited    = 0;
         done_seen = 1'b0;
         while (!done_seen && waited < max_len * 4) begin
            drive_cycle(0, 0, 0, 0, 0);
            waited++;
         end
         if (!done_seen) begin
            n_errors++;
            $display("frame %0d: done never rose after the scan ended", f);
         end
         $display("frame %0d mode %0d length %0d delay %0d markers passed %0d: %s",
                  f, mode, frame_len, frame_delay, scan_ptr,
                  (n_errors == errs_before) ? "ok" : "errors");
      end

      $display("frames %0d checks %0d errors %0d", n_frames, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/timed_flag_read_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module timed_flag_read_asserts #(
   parameter int addr_w = flag_read_pkg::def_addr_w,
   parameter int data_w = flag_read_pkg::def_data_w,
   parameter int len_w  = flag_read_pkg::def_len_w
) (
   input logic                        clk,
   input logic                        rst,
   input logic                        run,
   input flag_read_pkg::burst_state_t state,
   input logic                        databus_valid,
   input logic                        databus_ready,
   input logic [data_w-1:0]           databus_addr,
   input logic [len_w-1:0]            databus_len,
   input logic                        databus_last,
   input logic                        wr_en,
   input logic [addr_w-2:0]           wr_addr
);

   // request frozen until the last beat is taken
   property req_stable;
      @(posedge clk) disable iff (rst)
         databus_valid && !(databus_ready && databus_last)
            |=> $stable(databus_addr) && $stable(databus_len);
   endproperty

   a_req_stable: assert property (req_stable)
      else $error("databus request changed during a burst");

   a_burst_held: assert property (@(posedge clk) disable iff (rst)
      state == flag_read_pkg::burst_active && !(databus_ready && databus_last)
         |=> databus_valid)
      else $error("databus_valid dropped before the last beat");

   a_wr_from_zero: assert property (@(posedge clk) disable iff (rst)
      run |=> wr_addr == '0)
      else $error("first buffer write of a burst not at address zero");

   a_wr_steps: assert property (@(posedge clk) disable iff (rst)
      wr_en && !run |=> wr_addr == $past(wr_addr) + 1'b1) // one word per beat
      else $error("buffer write address did not step by one");

endmodule

bind burst_filler timed_flag_read_asserts #(
   .addr_w (addr_w),
   .data_w (data_w),
   .len_w  (len_w)
) u_asserts (
   .clk           (clk),
   .rst           (rst),
   .run           (run),
   .state         (state),
   .databus_valid (databus_valid),
   .databus_ready (databus_ready),
   .databus_addr  (databus_addr),
   .databus_len   (databus_len),
   .databus_last  (databus_last),
   .wr_en         (buf_wr.wr_en),
   .wr_addr       (buf_wr.wr_addr)
);

`default_nettype wire

//--- logic/timed_flag_read.sv
`timescale 1ns/1ps
`default_nettype none

module timed_flag_read #(
   parameter int addr_w = flag_read_pkg::def_addr_w,
   parameter int size_w = flag_read_pkg::def_size_w,
   parameter int data_w = flag_read_pkg::def_data_w,
   parameter int len_w  = flag_read_pkg::def_len_w
) (
   input  logic              clk,
   input  logic              rst,

   input  logic              run,
   input  logic              running,
   input  logic              disabled,
   output logic              done,

   output logic [31:0]       out0,
   input  logic [31:0]       in0,
   input  logic [31:0]       maximum,
   input  logic [31:0]       delay0,

   input  logic [data_w-1:0] ext_addr,
   input  logic [len_w-1:0]  length,

   // databus, read burst only
   output logic              databus_valid,
   input  logic              databus_ready,
   output logic [data_w-1:0] databus_addr,
   input  logic [data_w-1:0] databus_rdata,
   output logic [len_w-1:0]  databus_len,
   input  logic              databus_last
);

   flag_buf_if #(
      .addr_w (addr_w),
      .size_w (size_w)
   ) buf_if ();

   burst_filler #(
      .addr_w (addr_w),
      .size_w (size_w),
      .data_w (data_w),
      .len_w  (len_w)
   ) u_filler (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .ext_addr      (ext_addr),
      .length        (length),
      .databus_valid (databus_valid),
      .databus_ready (databus_ready),
      .databus_addr  (databus_addr),
      .databus_rdata (databus_rdata),
      .databus_len   (databus_len),
      .databus_last  (databus_last),
      .buf_wr        (buf_if.producer)
   );

   pingpong_ram #(
      .addr_w (addr_w),
      .size_w (size_w)
   ) u_ram (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .buf_port (buf_if.buffer)
   );

   marker_scanner #(
      .addr_w (addr_w),
      .size_w (size_w)
   ) u_scanner (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .running  (running),
      .disabled (disabled),
      .in0      (in0),
      .maximum  (maximum),
      .delay0   (delay0),
      .bus_busy (databus_valid), // done held off until the burst ends
      .out0     (out0),
      .done     (done),
      .buf_rd   (buf_if.consumer)
   );

endmodule

`default_nettype wire

//--- logic/marker_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module marker_scanner #(
   parameter int addr_w = flag_read_pkg::def_addr_w,
   parameter int size_w = flag_read_pkg::def_size_w
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        run,
   input  logic        running,
   input  logic        disabled,
   input  logic [31:0] in0,
   input  logic [31:0] maximum,
   input  logic [31:0] delay0,
   input  logic        bus_busy,
   output logic [31:0] out0,
   output logic        done,

   flag_buf_if.consumer buf_rd
);

   logic [addr_w-2:0] ptr; // next marker to fetch
   logic              pend; // read issued last cycle, rd_data valid now
   logic [size_w-1:0] cur;
   logic [size_w-1:0] nxt;
   logic              cur_v;
   logic              nxt_v;
   logic [1:0]        occ_next;
   logic [31:0]       delay;
   logic              delay_done;
   logic              hit;
   logic              advance;
   logic              still_valid;

   assign delay_done = (delay == 32'd0);
   assign hit        = cur_v && (in0[size_w-1:0] == cur);
   assign advance    = running && delay_done && hit;

   // markers held plus in flight, after this cycle's pop
   assign occ_next = {1'b0, cur_v} + {1'b0, nxt_v} + {1'b0, pend} - {1'b0, advance};

   assign buf_rd.rd_en   = !run && (occ_next < 2'd2);
   assign buf_rd.rd_addr = ptr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ptr   <= '0;
         pend  <= 1'b0;
         cur_v <= 1'b0;
         nxt_v <= 1'b0;
      end else if (run) begin
         ptr   <= '0;
         pend  <= 1'b0; // drop any stale read
         cur_v <= 1'b0;
         nxt_v <= 1'b0;
      end else begin
         pend <= buf_rd.rd_en;
         if (buf_rd.rd_en) begin
            ptr <= ptr + 1'b1;
         end
         if (advance) begin
            if (nxt_v) begin
               cur_v <= 1'b1;
               nxt_v <= pend;
            end else begin
               cur_v <= pend; // bypass straight from the ram
               nxt_v <= 1'b0;
            end
         end else if (pend) begin
            if (!cur_v) begin
               cur_v <= 1'b1;
            end else begin
               nxt_v <= 1'b1;
            end
         end
      end
   end

   // marker payload follows the valid bits above
   always_ff @(posedge clk) begin
      if (advance) begin
         cur <= nxt_v ? nxt : buf_rd.rd_data;
         if (nxt_v && pend) begin
            nxt <= buf_rd.rd_data;
         end
      end else if (pend) begin
         if (!cur_v) begin
            cur <= buf_rd.rd_data;
         end else begin
            nxt <= buf_rd.rd_data;
         end
      end
   end

   // out0 stays off for delay0+1 cycles after run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay <= 32'd0;
      end else if (run) begin
         delay <= delay0 + 32'd1;
      end else if (!delay_done) begin
         delay <= delay - 32'd1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         still_valid <= 1'b0;
      end else if (run) begin
         still_valid <= 1'b1;
      end else if (running && (in0 >= maximum)) begin
         still_valid <= 1'b0;
      end
   end

   assign out0 = (delay_done && !disabled && hit) ? 32'hffff_ffff : 32'd0;
   assign done = (!running || disabled || !still_valid) && !bus_busy; // wait for burst end

endmodule

`default_nettype wire

//--- logic/pingpong_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pingpong_ram #(
   parameter int addr_w = flag_read_pkg::def_addr_w,
   parameter int size_w = flag_read_pkg::def_size_w
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        run,
   flag_buf_if.buffer  buf_port
);

   logic [size_w-1:0] mem [0:2**addr_w-1];
   logic              bank; // bank being filled

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank <= 1'b0;
      end else if (run) begin
         bank <= ~bank;
      end
   end

   // fill one half while the other half is scanned
   always_ff @(posedge clk) begin
      if (buf_port.wr_en) begin
         mem[{bank, buf_port.wr_addr}] <= buf_port.wr_data;
      end
      if (buf_port.rd_en) begin
         buf_port.rd_data <= mem[{~bank, buf_port.rd_addr}]; // list from the previous run
      end
   end

endmodule

`default_nettype wire

//--- logic/burst_filler.sv
`timescale 1ns/1ps
`default_nettype none

module burst_filler #(
   parameter int addr_w = flag_read_pkg::def_addr_w,
   parameter int size_w = flag_read_pkg::def_size_w,
   parameter int data_w = flag_read_pkg::def_data_w,
   parameter int len_w  = flag_read_pkg::def_len_w
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  logic [data_w-1:0] ext_addr,
   input  logic [len_w-1:0]  length,

   output logic              databus_valid,
   input  logic              databus_ready,
   output logic [data_w-1:0] databus_addr,
   input  logic [data_w-1:0] databus_rdata,
   output logic [len_w-1:0]  databus_len,
   input  logic              databus_last,

   flag_buf_if.producer      buf_wr
);

   flag_read_pkg::burst_state_t state;

   logic [addr_w-2:0] beat; // index of the next returned word
   logic              beat_ok;

   assign databus_valid = (state == flag_read_pkg::burst_active);
   assign beat_ok       = databus_valid && databus_ready;

   // request held stable for the whole burst
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state        <= flag_read_pkg::burst_idle;
         beat         <= '0;
         databus_addr <= '0;
         databus_len  <= '0;
      end else if (run) begin
         state        <= flag_read_pkg::burst_active;
         beat         <= '0;
         databus_addr <= ext_addr;
         databus_len  <= length;
      end else if (beat_ok) begin
         beat <= beat + 1'b1;
         if (databus_last) begin
            state <= flag_read_pkg::burst_idle; // final beat of the burst
         end
      end
   end

   // returned word lands in the write bank in the same cycle
   assign buf_wr.wr_en   = beat_ok;
   assign buf_wr.wr_addr = beat;
   assign buf_wr.wr_data = databus_rdata[size_w-1:0]; // markers sit in the low bits

endmodule

`default_nettype wire

//--- logic/flag_buf_if.sv
`timescale 1ns/1ps
`default_nettype none

interface flag_buf_if #(
   parameter int addr_w = flag_read_pkg::def_addr_w,
   parameter int size_w = flag_read_pkg::def_size_w
);

   // bank-relative addresses, the bank bit is added inside the ram
   logic              wr_en;
   logic [addr_w-2:0] wr_addr;
   logic [size_w-1:0] wr_data;
   logic              rd_en;
   logic [addr_w-2:0] rd_addr;
   logic [size_w-1:0] rd_data;

   modport producer (
      output wr_en, wr_addr, wr_data
   );

   modport consumer (
      output rd_en, rd_addr,
      input  rd_data
   );

   modport buffer (
      input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
      output rd_data
   );

endinterface

`default_nettype wire

//--- logic/flag_read_pkg.sv
`default_nettype none

package flag_read_pkg;

   // buffer address, bank bit included
   parameter int def_addr_w = 10;

   parameter int def_size_w = 16; // marker width
   parameter int def_data_w = 32; // databus word and address
   parameter int def_len_w  = 8;  // burst length field

   typedef enum logic {
      burst_idle   = 1'b0,
      burst_active = 1'b1
   } burst_state_t;

endpackage

`default_nettype wire
